/* all.f */
+incdir+src
src/conv_pkg.sv
src/ifm_bank.sv
src/conv_ctrl.sv
src/window_buffer.sv
src/conv_mac.sv
src/psum_store.sv
src/conv_layer_top.sv
tb/tb_conv_layer.sv

/* src/conv_ctrl.sv */
`include "conv_macros.svh"

module conv_ctrl
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      start,
    input  logic      end_from_next,
    input  logic      layer_done,

    output logic      ready,
    output logic      start_next,

    output ifm_addr_t ifm_raddr,
    output pix_beat_t req
);

    localparam int PIX_PER_MAP = `IFM_SIZE * `IFM_SIZE;

    ctrl_state_t state, state_nx;

    logic [$clog2(PIX_PER_MAP)-1:0]  pix_cnt;
    logic [$clog2(`NUM_FILTERS)-1:0] filt_cnt;
    logic [$clog2(`IFM_DEPTH)-1:0]   depth_cnt;

    logic pass_end;
    logic filt_end;
    logic layer_end;

    assign pass_end  = (state == RUN) && (pix_cnt == PIX_PER_MAP - 1);
    assign filt_end  = pass_end && (filt_cnt == `NUM_FILTERS - 1);
    assign layer_end = filt_end && (depth_cnt == `IFM_DEPTH - 1);

    //////////////////////////////////////////////////////////////
    // run FSM
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_nx;
    end

    always_comb
    begin
        state_nx = state;
        case (state)
            IDLE:    if (start)         state_nx = RUN;
            RUN:     if (layer_end)     state_nx = DRAIN;
            DRAIN:   if (layer_done)    state_nx = HANDOFF;   // last psum written
            HANDOFF: if (end_from_next) state_nx = IDLE;
            default:                    state_nx = IDLE;
        endcase
    end

    assign ready      = (state == IDLE);
    assign start_next = (state == HANDOFF) && end_from_next;

    //////////////////////////////////////////////////////////////
    // depth outermost over the filter and pixel loops
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pix_cnt   <= '0;
            filt_cnt  <= '0;
            depth_cnt <= '0;
        end
        else if (state == RUN)
        begin
            pix_cnt <= pass_end ? '0 : pix_cnt + 1'b1;
            if (pass_end)
                filt_cnt <= filt_end ? '0 : filt_cnt + 1'b1;
            if (filt_end)
                depth_cnt <= layer_end ? '0 : depth_cnt + 1'b1;
        end
    end

    assign ifm_raddr = ifm_addr_t'(depth_cnt) * ifm_addr_t'(PIX_PER_MAP)
                     + ifm_addr_t'(pix_cnt);

    always_comb
    begin
        req.valid           = (state == RUN);
        req.tag.filter      = filt_cnt;
        req.tag.first_depth = (depth_cnt == 0);
        req.tag.last_depth  = (depth_cnt == `IFM_DEPTH - 1);
        req.tag.last_filter = (filt_cnt == `NUM_FILTERS - 1);
        req.pix             = '0;   // filled in by the bank
    end

    // the last psum write lands while draining
    a_done_in_drain: assert property (@(posedge clk) disable iff (reset)
        layer_done |-> state == DRAIN);

    // every loop has wrapped once the layer is swept
    a_loops_wrapped: assert property (@(posedge clk) disable iff (reset)
        state == DRAIN |-> pix_cnt == '0 && filt_cnt == '0 && depth_cnt == '0);

endmodule

/* src/conv_layer_top.sv */
module conv_layer_top
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       ifm_we,
    input  ifm_addr_t  ifm_waddr,
    input  pix_t       ifm_wdata,

    input  logic       wt_we,
    input  coef_addr_t wt_waddr,
    input  coef_t      wt_wdata,

    input  logic       start,
    output logic       ready,
    output logic       start_next,
    input  logic       end_from_next,

    input  logic       ofm_rd_req,
    input  ofm_addr_t  ofm_rd_addr,
    output logic       ofm_rd_grant,
    output logic       ofm_rd_valid,
    output acc_t       ofm_rd_data
);

    ifm_addr_t ifm_raddr;
    pix_beat_t req;
    pix_beat_t pix_beat;
    win_beat_t win;
    acc_beat_t acc;
    logic      layer_done;

    conv_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .end_from_next (end_from_next),
        .layer_done    (layer_done),
        .ready         (ready),
        .start_next    (start_next),
        .ifm_raddr     (ifm_raddr),
        .req           (req)
    );

    ifm_bank u_ifm_bank (
        .clk       (clk),
        .ifm_we    (ifm_we),
        .ifm_waddr (ifm_waddr),
        .ifm_wdata (ifm_wdata),
        .raddr     (ifm_raddr),
        .req       (req),
        .beat      (pix_beat)
    );

    window_buffer u_window (
        .clk   (clk),
        .reset (reset),
        .beat  (pix_beat),
        .win   (win)
    );

    conv_mac u_mac (
        .clk      (clk),
        .reset    (reset),
        .wt_we    (wt_we),
        .wt_waddr (wt_waddr),
        .wt_wdata (wt_wdata),
        .win      (win),
        .acc      (acc)
    );

    psum_store u_psum (
        .clk          (clk),
        .reset        (reset),
        .acc          (acc),
        .ofm_rd_req   (ofm_rd_req),
        .ofm_rd_addr  (ofm_rd_addr),
        .ofm_rd_grant (ofm_rd_grant),
        .ofm_rd_valid (ofm_rd_valid),
        .ofm_rd_data  (ofm_rd_data),
        .layer_done   (layer_done)
    );

endmodule

/* src/conv_mac.sv */
`include "conv_macros.svh"

module conv_mac
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       wt_we,
    input  coef_addr_t wt_waddr,
    input  coef_t      wt_wdata,

    input  win_beat_t  win,
    output acc_beat_t  acc
);

    localparam int TAPS      = `KSIZE * `KSIZE;
    localparam int BIAS_BASE = `NUM_FILTERS * `IFM_DEPTH * TAPS;

    coef_t coef [0:BIAS_BASE+`NUM_FILTERS-1];

    coef_addr_t depth_idx;
    coef_addr_t tap_base;
    coef_addr_t bias_addr;

    logic      s1_valid;
    pass_tag_t s1_tag;
    acc_t      s1_prod [0:TAPS-1];
    acc_t      sum;

    always_ff @(posedge clk)
    begin
        if (wt_we)
            coef[wt_waddr] <= wt_wdata;
    end

    // depth follows first_depth in a two-channel layer
    assign depth_idx = win.tag.first_depth ? coef_addr_t'(0) : coef_addr_t'(`IFM_DEPTH - 1);
    assign tap_base  = (coef_addr_t'(win.tag.filter) * coef_addr_t'(`IFM_DEPTH) + depth_idx)
                     * coef_addr_t'(TAPS);

    //////////////////////////////////////////////////////////////
    // stage 1 registers the nine products
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            s1_valid <= 1'b0;
        else
            s1_valid <= win.valid;
    end

    always_ff @(posedge clk)
    begin
        s1_tag <= win.tag;
        for (int k = 0; k < TAPS; k++)
            s1_prod[k] <= $signed({1'b0, win.pix[k]}) * coef[tap_base + coef_addr_t'(k)];
    end

    //////////////////////////////////////////////////////////////
    // stage 2 sums the products plus the bias on depth 0
    //////////////////////////////////////////////////////////////
    assign bias_addr = coef_addr_t'(BIAS_BASE) + coef_addr_t'(s1_tag.filter);

    always_comb
    begin
        sum = s1_tag.first_depth ? acc_t'(coef[bias_addr]) : '0;
        for (int k = 0; k < TAPS; k++)
            sum = sum + s1_prod[k];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            acc.valid <= 1'b0;
        else
        begin
            acc.valid <= s1_valid;
            acc.tag   <= s1_tag;
            acc.sum   <= sum;
        end
    end

endmodule

/* src/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

//////////////////////////////////////////////////////////////
// layer geometry
//////////////////////////////////////////////////////////////
`define IFM_SIZE     6
`define KSIZE        3
`define IFM_DEPTH    2
`define NUM_FILTERS  2
`define OFM_SIZE     4   // no padding and stride 1

//////////////////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////////////////
`define PIX_W        8
`define WT_W         8   // weights and biases
`define ACC_W        20

`endif

/* src/conv_pkg.sv */
`include "conv_macros.svh"

package conv_pkg;

    typedef logic        [`PIX_W-1:0] pix_t;
    typedef logic signed [`WT_W-1:0]  coef_t;
    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic [6:0] ifm_addr_t;   // depth * 36 + pixel
    typedef logic [5:0] coef_addr_t;  // weights 0..35 then biases 36..37
    typedef logic [4:0] ofm_addr_t;   // filter * 16 + position

    // pass identity carried alongside every pixel
    typedef struct packed {
        logic [$clog2(`NUM_FILTERS)-1:0] filter;
        logic                            first_depth;
        logic                            last_depth;
        logic                            last_filter;
    } pass_tag_t;

    typedef struct packed {
        logic      valid;
        pass_tag_t tag;
        pix_t      pix;
    } pix_beat_t;

    typedef struct packed {
        logic                           valid;
        pass_tag_t                      tag;
        pix_t [`KSIZE*`KSIZE-1:0]       pix;  // row-major from the top left
    } win_beat_t;

    typedef struct packed {
        logic      valid;
        pass_tag_t tag;
        acc_t      sum;
    } acc_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        HANDOFF
    } ctrl_state_t;

endpackage

/* src/ifm_bank.sv */
`include "conv_macros.svh"

module ifm_bank
    import conv_pkg::*;
(
    input  logic      clk,

    input  logic      ifm_we,
    input  ifm_addr_t ifm_waddr,
    input  pix_t      ifm_wdata,

    input  ifm_addr_t raddr,
    input  pix_beat_t req,
    output pix_beat_t beat
);

    localparam int WORDS = `IFM_DEPTH * `IFM_SIZE * `IFM_SIZE;

    pix_t mem [0:WORDS-1];

    always_ff @(posedge clk)
    begin
        if (ifm_we)
            mem[ifm_waddr] <= ifm_wdata;   // previous layer fills the bank
    end

    // tag and valid ride along with the read data
    always_ff @(posedge clk)
    begin
        beat     <= req;
        beat.pix <= mem[raddr];
    end

endmodule

/* src/psum_store.sv */
`include "conv_macros.svh"

module psum_store
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  acc_beat_t acc,

    input  logic      ofm_rd_req,
    input  ofm_addr_t ofm_rd_addr,
    output logic      ofm_rd_grant,
    output logic      ofm_rd_valid,
    output acc_t      ofm_rd_data,

    output logic      layer_done
);

    localparam int OFM_PIX = `OFM_SIZE * `OFM_SIZE;

    acc_t mem [0:`NUM_FILTERS*OFM_PIX-1];

    logic [$clog2(OFM_PIX)-1:0] pos;
    ofm_addr_t                  wr_addr;
    acc_t                       wr_data;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pos <= '0;
        else if (acc.valid)
            pos <= (pos == OFM_PIX - 1) ? '0 : pos + 1'b1;
    end

    //////////////////////////////////////////////////////////////
    // accumulate path
    //////////////////////////////////////////////////////////////
    assign wr_addr = ofm_addr_t'(acc.tag.filter) * ofm_addr_t'(OFM_PIX) + ofm_addr_t'(pos);

    always_comb
    begin
        wr_data = acc.tag.first_depth ? acc.sum : mem[wr_addr] + acc.sum;
        if (acc.tag.last_depth && wr_data[`ACC_W-1])
            wr_data = '0;   // relu on the final depth
    end

    assign layer_done = acc.valid && acc.tag.last_depth && acc.tag.last_filter
                     && (pos == OFM_PIX - 1);

    //////////////////////////////////////////////////////////////
    // external read port behind the accumulate path
    //////////////////////////////////////////////////////////////
    assign ofm_rd_grant = ofm_rd_req && !acc.valid;

    always_ff @(posedge clk)
    begin
        if (acc.valid)
            mem[wr_addr] <= wr_data;
        if (ofm_rd_grant)
            ofm_rd_data <= mem[ofm_rd_addr];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ofm_rd_valid <= 1'b0;
        else
            ofm_rd_valid <= ofm_rd_grant;
    end

    // a waiting requester keeps its request and address
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        ofm_rd_req && !ofm_rd_grant |=> ofm_rd_req && $stable(ofm_rd_addr));

endmodule

/* src/window_buffer.sv */
`include "conv_macros.svh"

module window_buffer
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  pix_beat_t beat,
    output win_beat_t win
);

    localparam int SPAN  = (`KSIZE - 1) * `IFM_SIZE + `KSIZE;   // two rows plus three
    localparam int CNT_W = $clog2(`IFM_SIZE);

    pix_t hist [1:SPAN-1];
    pix_t span [0:SPAN-1];

    logic [CNT_W-1:0] col;
    logic [CNT_W-1:0] row;

    // span[0] is the incoming pixel with older ones behind it
    always_comb
    begin
        span[0] = beat.pix;
        for (int i = 1; i < SPAN; i++)
            span[i] = hist[i];
    end

    always_ff @(posedge clk)
    begin
        if (beat.valid)
        begin
            for (int i = 1; i < SPAN; i++)
                hist[i] <= span[i-1];
        end
    end

    // position of the incoming pixel wrapping every 36
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            col <= '0;
            row <= '0;
        end
        else if (beat.valid)
        begin
            if (col == `IFM_SIZE - 1)
            begin
                col <= '0;
                row <= (row == `IFM_SIZE - 1) ? '0 : row + 1'b1;
            end
            else
                col <= col + 1'b1;
        end
    end

    always_comb
    begin
        win.valid = beat.valid && (row >= `KSIZE - 1) && (col >= `KSIZE - 1);
        win.tag   = beat.tag;
        for (int ky = 0; ky < `KSIZE; ky++)
            for (int kx = 0; kx < `KSIZE; kx++)
                win.pix[ky*`KSIZE + kx] = span[(`KSIZE-1-ky)*`IFM_SIZE + (`KSIZE-1-kx)];
    end

endmodule

/* tb/tb_conv_layer.sv */
`include "conv_macros.svh"

module tb_conv_layer
    import conv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAP_PIX      = `IFM_SIZE * `IFM_SIZE;
    localparam int IFM_WORDS    = `IFM_DEPTH * MAP_PIX;
    localparam int TAPS         = `KSIZE * `KSIZE;
    localparam int BIAS_BASE    = `NUM_FILTERS * `IFM_DEPTH * TAPS;
    localparam int COEF_WORDS   = BIAS_BASE + `NUM_FILTERS;
    localparam int OFM_PIX      = `OFM_SIZE * `OFM_SIZE;
    localparam int LAYER_CYCLES = `IFM_DEPTH * `NUM_FILTERS * MAP_PIX + 8;
    localparam int READ_CYCLES  = `NUM_FILTERS * OFM_PIX * 3;
    localparam int HOLD_CYCLES  = 300;
    localparam int TEST_CYCLES  = 10 + (IFM_WORDS + COEF_WORDS + LAYER_CYCLES + READ_CYCLES)
                                + 4 + (HOLD_CYCLES + 10) + (LAYER_CYCLES + 20 + READ_CYCLES)
                                + (COEF_WORDS + LAYER_CYCLES + READ_CYCLES);

    logic       clk;
    logic       reset;
    logic       ifm_we;
    ifm_addr_t  ifm_waddr;
    pix_t       ifm_wdata;
    logic       wt_we;
    coef_addr_t wt_waddr;
    coef_t      wt_wdata;
    logic       start;
    logic       ready;
    logic       start_next;
    logic       end_from_next;
    logic       ofm_rd_req;
    ofm_addr_t  ofm_rd_addr;
    logic       ofm_rd_grant;
    logic       ofm_rd_valid;
    acc_t       ofm_rd_data;

    int ifm_m  [0:IFM_WORDS-1];
    int coef_m [0:COEF_WORDS-1];
    int error_count = 0;
    int next_pulses = 0;

    conv_layer_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (start_next === 1'b1)
            next_pulses++;   // hand-off pulses seen so far
    end

    //////////////////////////////////////////////////////////////
    // error reporting and reference model
    //////////////////////////////////////////////////////////////
    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_error($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    function automatic int model_output(input int f, input int oy, input int ox);
        int s;
        s = coef_m[BIAS_BASE + f];
        for (int d = 0; d < `IFM_DEPTH; d++)
            for (int ky = 0; ky < `KSIZE; ky++)
                for (int kx = 0; kx < `KSIZE; kx++)
                    s += ifm_m[d*MAP_PIX + (oy+ky)*`IFM_SIZE + ox + kx]
                       * coef_m[(f*`IFM_DEPTH + d)*TAPS + ky*`KSIZE + kx];
        return (s < 0) ? 0 : s;   // relu after the last depth
    endfunction

    //////////////////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////////////////
    task automatic load_pixels();
        for (int a = 0; a < IFM_WORDS; a++)
        begin
            ifm_m[a] = $urandom_range(15, 0);
            @(negedge clk);
            ifm_we    = 1'b1;
            ifm_waddr = ifm_addr_t'(a);
            ifm_wdata = pix_t'(ifm_m[a]);
        end
        @(negedge clk);
        ifm_we = 1'b0;
    endtask

    task automatic load_weights();
        for (int a = 0; a < COEF_WORDS; a++)
        begin
            coef_m[a] = int'($urandom_range(15, 0)) - 8;
            @(negedge clk);
            wt_we    = 1'b1;
            wt_waddr = coef_addr_t'(a);
            wt_wdata = coef_t'(coef_m[a]);
        end
        @(negedge clk);
        wt_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // returns at the edge where start_next is seen
    task automatic wait_for_handoff(input int limit);
        int waited;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            assert (waited <= limit)
            else report_error($sformatf("no start_next within %0d cycles", limit));
        end
        while (start_next !== 1'b1);
    endtask

    task automatic read_ofm(input int addr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        ofm_rd_req  = 1'b1;
        ofm_rd_addr = ofm_addr_t'(addr);
        do
        begin
            @(posedge clk);
            waited++;
            assert (waited <= 20)
            else report_error("read request was never granted");
        end
        while (ofm_rd_grant !== 1'b1);
        @(negedge clk);
        ofm_rd_req = 1'b0;
        @(posedge clk);
        check_value("ofm_rd_valid", 32'(ofm_rd_valid), 32'h1);
        data = {{(32-`ACC_W){1'b0}}, ofm_rd_data};
    endtask

    task automatic check_outputs();
        logic [31:0] got;
        for (int f = 0; f < `NUM_FILTERS; f++)
            for (int oy = 0; oy < `OFM_SIZE; oy++)
                for (int ox = 0; ox < `OFM_SIZE; ox++)
                begin
                    read_ofm(f*OFM_PIX + oy*`OFM_SIZE + ox, got);
                    check_value($sformatf("ofm_rd_data[%0d]", f*OFM_PIX + oy*`OFM_SIZE + ox),
                                got, 32'(model_output(f, oy, ox)));
                end
    endtask

    //////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////
    task automatic verify_reset_state();
        @(posedge clk);
        check_value("ready", 32'(ready), 32'h1);
        check_value("start_next", 32'(start_next), 32'h0);
        check_value("ofm_rd_grant", 32'(ofm_rd_grant), 32'h0);
        check_value("ofm_rd_valid", 32'(ofm_rd_valid), 32'h0);
    endtask

    task automatic run_full_layer();
        load_pixels();
        load_weights();
        end_from_next = 1'b1;
        pulse_start();
        wait_for_handoff(LAYER_CYCLES + 20);
        check_outputs();
    endtask

    task automatic read_while_idle();
        @(negedge clk);
        ofm_rd_req  = 1'b1;
        ofm_rd_addr = ofm_addr_t'(5);
        @(posedge clk);
        check_value("ofm_rd_grant", 32'(ofm_rd_grant), 32'h1);   // same cycle while idle
        @(negedge clk);
        ofm_rd_req = 1'b0;
        @(posedge clk);
        check_value("ofm_rd_valid", 32'(ofm_rd_valid), 32'h1);
        check_value("ofm_rd_data", {{(32-`ACC_W){1'b0}}, ofm_rd_data},
                    32'(model_output(0, 1, 1)));
    endtask

    task automatic hold_handoff();
        int pulses_before;
        @(negedge clk);
        end_from_next = 1'b0;
        pulses_before = next_pulses;
        pulse_start();
        repeat (HOLD_CYCLES)
        begin
            @(posedge clk);
            check_value("start_next", 32'(start_next), 32'h0);
            check_value("ready", 32'(ready), 32'h0);
        end
        @(negedge clk);
        end_from_next = 1'b1;
        wait_for_handoff(4);
        @(posedge clk);
        check_value("ready", 32'(ready), 32'h1);
        repeat (4) @(posedge clk);
        check_value("start_next pulse count", 32'(next_pulses - pulses_before), 32'h1);
    endtask

    task automatic ignore_mid_run_start();
        int pulses_before;
        pulses_before = next_pulses;
        pulse_start();
        repeat (40) @(posedge clk);
        pulse_start();   // ignored in the middle of a run
        wait_for_handoff(LAYER_CYCLES - 40);   // still due one layer after the first start
        repeat (20) @(posedge clk);
        check_value("start_next pulse count", 32'(next_pulses - pulses_before), 32'h1);
        check_value("ready", 32'(ready), 32'h1);
        check_outputs();
    endtask

    task automatic rerun_with_new_weights();
        load_weights();
        pulse_start();
        wait_for_handoff(LAYER_CYCLES + 20);
        check_outputs();
    endtask

    //////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////
    initial
    begin
        void'($urandom(32'h7a7d));
        reset         = 1'b1;
        ifm_we        = 1'b0;
        ifm_waddr     = '0;
        ifm_wdata     = '0;
        wt_we         = 1'b0;
        wt_waddr      = '0;
        wt_wdata      = '0;
        start         = 1'b0;
        end_from_next = 1'b0;
        ofm_rd_req    = 1'b0;
        ofm_rd_addr   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        verify_reset_state();
        run_full_layer();
        read_while_idle();
        hold_handoff();
        ignore_mid_run_start();
        rerun_with_new_weights();

        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        repeat (20 * TEST_CYCLES) @(posedge clk);
        report_error("watchdog expired before the tests finished");
    end

endmodule
